/* vlog.f */
rtl/nf_pkg.sv
rtl/nf_ram.sv
rtl/nf_reg_file.sv
rtl/nf_decoder.sv
rtl/nf_hazard_unit.sv
rtl/nf_pipe_core.sv
testbench/nf_clock_gen.sv
testbench/nf_pipe_core_properties.sv
testbench/nf_pipe_core_tb.sv

/* Makefile */
TOP = nf_pipe_core_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/nf_pipe_core_tb.sv */
// directed and random program tests for the pipeline core against an instruction-level model
`timescale 1ns/1ns

module nf_pipe_core_tb;

    localparam int IMEM_DEPTH  = 128; // longest program plus stalls stays below the wrap
    localparam int DMEM_DEPTH  = 64;
    localparam int NUM_TESTS   = 6;
    // each test loads and runs a full image
    localparam int CYCLE_LIMIT = 6 * NUM_TESTS * IMEM_DEPTH + 200;

    logic               clk;
    logic               reset;
    logic               restart;
    logic               run;
    logic               imem_we;
    nf_pkg::word_t      imem_addr;
    nf_pkg::word_t      imem_wdata;
    logic               wb_valid;
    nf_pkg::reg_addr_t  wb_addr;
    nf_pkg::word_t      wb_data;

    nf_pkg::word_t      prog [$];
    nf_pkg::reg_addr_t  exp_addr [$];   // expected register writes in program order
    nf_pkg::word_t      exp_data [$];
    nf_pkg::word_t      model_regs [32];
    nf_pkg::word_t      model_mem [DMEM_DEPTH];
    int                 checks;
    int                 value_errors;
    int                 other_errors;
    int                 cycles = 0;

    nf_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) clock_gen
    (
        .clk        (clk),
        .reset      (reset),
        .restart    (restart)
    );

    nf_pipe_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) nf_pipe_core_inst
    (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    bind nf_pipe_core nf_pipe_core_properties properties_inst
    (
        .clk        (clk),
        .reset      (reset),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .stall_if   (stall_if),
        .stall_id   (stall_id),
        .flush_iexe (flush_iexe)
    );

    // instruction encoders
    function automatic nf_pkg::word_t reg_reg(nf_pkg::alu_op_t op, int rd, int rs1, int rs2);
        logic [6:0] funct7;
        logic [2:0] funct3;
        funct7 = (op == nf_pkg::ALU_SUB) ? nf_pkg::F7_SUB : 7'b0;
        case (op)
            nf_pkg::ALU_AND: funct3 = nf_pkg::F3_AND;
            nf_pkg::ALU_OR:  funct3 = nf_pkg::F3_OR;
            default:         funct3 = nf_pkg::F3_ADD_SUB;
        endcase
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], nf_pkg::OP_R};
    endfunction

    function automatic nf_pkg::word_t add_imm(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], nf_pkg::F3_ADD_SUB, rd[4:0], nf_pkg::OP_I};
    endfunction

    function automatic nf_pkg::word_t load_word(int rd, int rs1, int offset);
        return {offset[11:0], rs1[4:0], nf_pkg::F3_LW_SW, rd[4:0], nf_pkg::OP_LOAD};
    endfunction

    function automatic nf_pkg::word_t store_word(int rs2, int rs1, int offset);
        return {offset[11:5], rs2[4:0], rs1[4:0], nf_pkg::F3_LW_SW, offset[4:0], nf_pkg::OP_STORE};
    endfunction

    task automatic compare_word(string name, nf_pkg::word_t actual, nf_pkg::word_t expected);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_reg_addr(string name, nf_pkg::reg_addr_t actual,
                                    nf_pkg::reg_addr_t expected);
        checks++;
        if (actual !== expected)
        begin
            value_errors++;
            $display("FAILED at %0t: %s expected x%0d got x%0d", $time, name, expected, actual);
        end
    endtask

    // executes the program in order and records each register write
    task automatic run_model();
        nf_pkg::word_t      instr;
        nf_pkg::word_t      a;
        nf_pkg::word_t      b;
        nf_pkg::word_t      imm_i;
        nf_pkg::word_t      imm_s;
        nf_pkg::word_t      result;
        nf_pkg::reg_addr_t  rd;
        logic               writes;
        exp_addr.delete();
        exp_data.delete();
        foreach (prog[i])
        begin
            instr  = prog[i];
            rd     = instr[11:7];
            a      = model_regs[instr[19:15]];
            b      = model_regs[instr[24:20]];
            imm_i  = {{20{instr[31]}}, instr[31:20]};
            imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            writes = 1'b1;
            result = '0;
            case (instr[6:0])
                nf_pkg::OP_R:
                    case (instr[14:12])
                        nf_pkg::F3_AND: result = a & b;
                        nf_pkg::F3_OR:  result = a | b;
                        default:        result = instr[30] ? a - b : a + b;
                    endcase
                nf_pkg::OP_I:    result = a + imm_i;
                nf_pkg::OP_LOAD: result = model_mem[((a + imm_i) >> 2) % DMEM_DEPTH];
                default:
                begin
                    model_mem[((a + imm_s) >> 2) % DMEM_DEPTH] = b; // sw
                    writes = 1'b0;
                end
            endcase
            if (writes && (rd != 0))
            begin
                model_regs[rd] = result;
                exp_addr.push_back(rd);
                exp_data.push_back(result);
            end
        end
    endtask

    task automatic check_idle();
        if (wb_valid)
        begin
            other_errors++;
            $display("wb_valid pulsed at %0t while run was low", $time);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        while (reset)
        begin
            @(negedge clk);
            check_idle();
        end
    endtask

    // fills the whole instruction memory and pads with nops tagged by their address
    task automatic load_image();
        for (int i = 0; i < IMEM_DEPTH; i++)
        begin
            imem_we    = 1'b1;
            imem_addr  = i;
            imem_wdata = (i < prog.size()) ? prog[i] : add_imm(0, 0, i);
            @(negedge clk);
            check_idle();
        end
        imem_we = 1'b0;
    endtask

    task automatic run_program(string name);
        int seen;
        apply_reset();
        load_image();
        run_model();
        seen = 0;
        run  = 1'b1;
        while (seen < exp_addr.size())
        begin
            @(negedge clk);
            if (wb_valid)
            begin
                compare_reg_addr("wb_addr", wb_addr, exp_addr[seen]);
                compare_word("wb_data", wb_data, exp_data[seen]);
                seen++;
            end
        end
        repeat (8) // any pulse after the last expected write is an extra one
        begin
            @(negedge clk);
            if (wb_valid)
                seen++;
        end
        if (seen != exp_addr.size())
        begin
            other_errors++;
            $display("%s: %0d register writes seen, %0d expected", name, seen, exp_addr.size());
        end
        run = 1'b0;
    endtask

    task automatic test_reset_idle();
        prog.delete();
        prog.push_back(add_imm(1, 0, 5)); // loaded but never started
        apply_reset();
        load_image();
        repeat (20)
        begin
            @(negedge clk);
            check_idle();
        end
    endtask

    task automatic test_independent();
        prog.delete();
        prog.push_back(add_imm(1, 0, 13));
        prog.push_back(add_imm(2, 0, -7));
        prog.push_back(add_imm(3, 0, 677));
        repeat (3)
            prog.push_back(add_imm(0, 0, 0));
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 4, 1, 2));
        prog.push_back(reg_reg(nf_pkg::ALU_SUB, 5, 1, 3));
        prog.push_back(reg_reg(nf_pkg::ALU_AND, 6, 2, 3));
        prog.push_back(reg_reg(nf_pkg::ALU_OR, 7, 1, 2));
        run_program("independent");
    endtask

    task automatic test_dependencies();
        prog.delete();
        prog.push_back(add_imm(1, 0, 100));
        prog.push_back(add_imm(2, 1, 5));                   // rs1 at distance one
        prog.push_back(reg_reg(nf_pkg::ALU_SUB, 3, 0, 2));  // rs2 at distance one
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 4, 2, 3));  // distance two and one
        prog.push_back(reg_reg(nf_pkg::ALU_OR, 5, 1, 3));   // rs2 at distance two
        prog.push_back(reg_reg(nf_pkg::ALU_AND, 6, 3, 4));  // rs1 through the register file
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 7, 5, 4));  // rs2 at distance three
        prog.push_back(add_imm(1, 1, 1));
        prog.push_back(add_imm(1, 1, 1));
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 2, 1, 1));  // newest x1 must win
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 3, 2, 1));
        prog.push_back(add_imm(4, 0, 3));
        prog.push_back(add_imm(0, 0, 0));
        prog.push_back(add_imm(0, 0, 0));
        prog.push_back(reg_reg(nf_pkg::ALU_SUB, 5, 6, 4));
        run_program("dependencies");
    endtask

    task automatic test_load_use();
        prog.delete();
        prog.push_back(add_imm(1, 0, 77));
        prog.push_back(store_word(1, 0, 8));
        prog.push_back(load_word(2, 0, 8));
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 3, 2, 2)); // waits one cycle for the load
        prog.push_back(load_word(4, 0, 8));
        prog.push_back(reg_reg(nf_pkg::ALU_SUB, 5, 0, 4));
        prog.push_back(add_imm(6, 4, 1));
        run_program("load-use");
    endtask

    task automatic test_store_load();
        prog.delete();
        prog.push_back(add_imm(1, 0, 12));
        prog.push_back(add_imm(2, 0, -300));
        prog.push_back(store_word(2, 1, 4)); // data from the previous instruction
        prog.push_back(load_word(3, 1, 4));
        prog.push_back(add_imm(4, 0, 85));
        prog.push_back(store_word(4, 0, 20));
        prog.push_back(load_word(5, 0, 20));
        prog.push_back(reg_reg(nf_pkg::ALU_ADD, 6, 3, 5));
        run_program("store-load");
    endtask

    task automatic test_random();
        int op;
        int rd;
        int rs1;
        int rs2;
        prog.delete();
        for (int r = 1; r < 8; r++)
            prog.push_back(add_imm(r, 0, int'($urandom_range(0, 4095)) - 2048));
        for (int w = 0; w < 8; w++)
            prog.push_back(store_word(w % 7 + 1, 0, w * 4)); // every word a load can reach
        repeat (40)
        begin
            op  = $urandom_range(0, 6);
            rd  = $urandom_range(1, 7);
            rs1 = $urandom_range(1, 7);
            rs2 = $urandom_range(1, 7);
            case (op)
                0, 1, 2, 3: prog.push_back(reg_reg(nf_pkg::alu_op_t'(op), rd, rs1, rs2));
                4:          prog.push_back(add_imm(rd, rs1, int'($urandom_range(0, 4095)) - 2048));
                5:          prog.push_back(load_word(rd, 0, int'($urandom_range(0, 7)) * 4));
                default:    prog.push_back(store_word(rs2, 0, int'($urandom_range(0, 7)) * 4));
            endcase
        end
        run_program("random");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'h1c39bcad));
        restart      = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        foreach (model_mem[i])
            model_mem[i] = '0;
        test_reset_idle();
        test_independent();
        test_dependencies();
        test_load_use();
        test_store_load();
        test_random();
        $display("%0d checks, %0d value errors, %0d other errors, %0d assertion failures",
                 checks, value_errors, other_errors, nf_pipe_core_inst.properties_inst.failures);
        if ((value_errors + other_errors + nf_pipe_core_inst.properties_inst.failures) == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : nf_pipe_core_tb

/* testbench/nf_pipe_core_properties.sv */
// concurrent assertions on the writeback port and hazard controls, bound into the pipeline core
`timescale 1ns/1ns

module nf_pipe_core_properties
(
    input   logic               clk,
    input   logic               reset,
    input   logic               wb_valid,
    input   nf_pkg::reg_addr_t  wb_addr,
    input   logic               stall_if,
    input   logic               stall_id,
    input   logic               flush_iexe
);

    int failures = 0; // read by the testbench summary

    // writes to x0 are dropped in decode and never reach the port
    property wb_never_x0;
        @(posedge clk) disable iff (reset)
        wb_valid |-> (wb_addr != '0);
    endproperty

    // a load-use hazard holds fetch and decode and bubbles execute together
    property stall_flush_equal;
        @(posedge clk) disable iff (reset)
        (stall_if == stall_id) && (stall_id == flush_iexe);
    endproperty

    property quiet_after_reset;
        @(posedge clk)
        reset |=> !wb_valid;
    endproperty

    wb_addr_check: assert property (wb_never_x0)
    else
    begin
        failures++;
        $error("register write to x0 on the writeback port");
    end

    stall_check: assert property (stall_flush_equal)
    else
    begin
        failures++;
        $error("stall_if, stall_id and flush_iexe disagree");
    end

    reset_check: assert property (quiet_after_reset)
    else
    begin
        failures++;
        $error("wb_valid high in the cycle after reset");
    end

endmodule : nf_pipe_core_properties

/* testbench/nf_clock_gen.sv */
// clock and reset source for the testbench, reset is held at start and again whenever restart is seen
`timescale 1ns/1ns

module nf_clock_gen
#(
    parameter PERIOD       = 40,
    parameter RESET_CYCLES = 5
)
(
    output  logic   clk,
    output  logic   reset,
    input   logic   restart     // starts a new reset sequence at the next rising edge
);

    int remaining = RESET_CYCLES; // reset cycles still to go

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (restart)
            remaining <= RESET_CYCLES;
        else if (remaining != 0)
            remaining <= remaining - 1;
    end

    assign reset = (remaining != 0);

endmodule : nf_clock_gen

/* rtl/nf_pipe_core.sv */
// five stage RV32I subset pipeline top with instruction load port and writeback trace outputs
`timescale 1ns/1ns

module nf_pipe_core
#(
    parameter IMEM_DEPTH = 64,
    parameter DMEM_DEPTH = 64
)
(
    input   logic               clk,
    input   logic               reset,
    input   logic               run,
    input   logic               imem_we,
    input   nf_pkg::word_t      imem_addr,
    input   nf_pkg::word_t      imem_wdata,
    output  logic               wb_valid,
    output  nf_pkg::reg_addr_t  wb_addr,
    output  nf_pkg::word_t      wb_data
);

    // fetch
    nf_pkg::word_t      pc;         // word index
    nf_pkg::word_t      imem_raddr;
    nf_pkg::word_t      instr_if;
    // decode
    logic               id_valid;
    nf_pkg::word_t      id_instr;
    nf_pkg::word_t      dec_instr;
    nf_pkg::reg_addr_t  ra1_id;
    nf_pkg::reg_addr_t  ra2_id;
    nf_pkg::reg_addr_t  dec_wa3;
    nf_pkg::word_t      dec_imm;
    nf_pkg::alu_op_t    dec_alu_op;
    logic               dec_alu_src_imm;
    logic               dec_we_rf;
    logic               dec_rf_src;
    logic               dec_we_mem;
    nf_pkg::word_t      rf_rd1;
    nf_pkg::word_t      rf_rd2;
    // execute
    logic               exe_valid;
    nf_pkg::reg_addr_t  exe_ra1;
    nf_pkg::reg_addr_t  exe_ra2;
    nf_pkg::reg_addr_t  exe_wa3;
    nf_pkg::word_t      exe_rd1;
    nf_pkg::word_t      exe_rd2;
    nf_pkg::word_t      exe_imm;
    nf_pkg::alu_op_t    exe_alu_op;
    logic               exe_alu_src_imm;
    logic               exe_we_rf;
    logic               exe_rf_src;
    logic               exe_we_mem;
    nf_pkg::word_t      src_a;
    nf_pkg::word_t      fwd_rd2;
    nf_pkg::word_t      src_b;
    nf_pkg::word_t      alu_result;
    // memory
    logic               mem_valid;
    nf_pkg::reg_addr_t  mem_wa3;
    nf_pkg::word_t      mem_alu;
    nf_pkg::word_t      mem_store_data;
    logic               mem_we_rf;
    logic               mem_rf_src;
    logic               mem_we_mem;
    nf_pkg::word_t      dmem_rdata;
    // writeback
    logic               wb_stage_valid;
    nf_pkg::reg_addr_t  wb_wa3;
    nf_pkg::word_t      wb_result;
    logic               wb_we_rf;
    // hazard unit
    nf_pkg::bypass_t    rd1_bypass;
    nf_pkg::bypass_t    rd2_bypass;
    logic               stall_if;
    logic               stall_id;
    logic               flush_iexe;

    // fetch stage
    always_ff @(posedge clk)
    begin
        if (reset || !run)
            pc <= '0;
        else if (!stall_if)
            pc <= pc + 1'b1;
    end

    assign imem_raddr = run ? pc : imem_addr; // loader owns the port while idle

    nf_ram #(.DEPTH(IMEM_DEPTH)) instr_mem
    (
        .clk    (clk),
        .we     (imem_we && !run),
        .addr   (imem_raddr),
        .wdata  (imem_wdata),
        .rdata  (instr_if)
    );

    // fetch to decode register
    always_ff @(posedge clk)
    begin
        if (reset || !run)
            id_valid <= 1'b0;
        else if (!stall_id)
            id_valid <= 1'b1;
        if (!stall_id)
            id_instr <= instr_if;
    end

    // decode stage, a bubble decodes as all zero
    assign dec_instr = id_valid ? id_instr : '0;

    nf_decoder decoder
    (
        .instr          (dec_instr),
        .ra1            (ra1_id),
        .ra2            (ra2_id),
        .wa3            (dec_wa3),
        .imm            (dec_imm),
        .alu_op         (dec_alu_op),
        .alu_src_imm    (dec_alu_src_imm),
        .we_rf          (dec_we_rf),
        .rf_src         (dec_rf_src),
        .we_mem         (dec_we_mem)
    );

    nf_reg_file reg_file
    (
        .clk    (clk),
        .ra1    (ra1_id),
        .ra2    (ra2_id),
        .rd1    (rf_rd1),
        .rd2    (rf_rd2),
        .wa3    (wb_wa3),
        .we3    (wb_valid),
        .wd3    (wb_result)
    );

    // decode to execute register
    always_ff @(posedge clk)
    begin
        if (reset || !run || flush_iexe)
            exe_valid <= 1'b0;
        else
            exe_valid <= id_valid;
        exe_ra1         <= ra1_id;
        exe_ra2         <= ra2_id;
        exe_wa3         <= dec_wa3;
        exe_rd1         <= rf_rd1;
        exe_rd2         <= rf_rd2;
        exe_imm         <= dec_imm;
        exe_alu_op      <= dec_alu_op;
        exe_alu_src_imm <= dec_alu_src_imm;
        exe_we_rf       <= dec_we_rf;
        exe_rf_src      <= dec_rf_src;
        exe_we_mem      <= dec_we_mem;
    end

    // execute stage operand muxes
    always_comb
    begin
        case (rd1_bypass)
            nf_pkg::BP_MEM: src_a = mem_alu;
            nf_pkg::BP_WB:  src_a = wb_result;
            default:        src_a = exe_rd1;
        endcase
        case (rd2_bypass)
            nf_pkg::BP_MEM: fwd_rd2 = mem_alu;
            nf_pkg::BP_WB:  fwd_rd2 = wb_result;
            default:        fwd_rd2 = exe_rd2;
        endcase
    end

    assign src_b = exe_alu_src_imm ? exe_imm : fwd_rd2;

    always_comb
    begin
        case (exe_alu_op)
            nf_pkg::ALU_SUB: alu_result = src_a - src_b;
            nf_pkg::ALU_AND: alu_result = src_a & src_b;
            nf_pkg::ALU_OR:  alu_result = src_a | src_b;
            default:         alu_result = src_a + src_b; // also lw/sw address
        endcase
    end

    // execute to memory register
    always_ff @(posedge clk)
    begin
        if (reset || !run)
            mem_valid <= 1'b0;
        else
            mem_valid <= exe_valid;
        mem_wa3        <= exe_wa3;
        mem_alu        <= alu_result;
        mem_store_data <= fwd_rd2;   // forwarded store data
        mem_we_rf      <= exe_we_rf;
        mem_rf_src     <= exe_rf_src;
        mem_we_mem     <= exe_we_mem;
    end

    // memory stage, byte address down to a word index
    nf_ram #(.DEPTH(DMEM_DEPTH)) data_mem
    (
        .clk    (clk),
        .we     (mem_valid && mem_we_mem),
        .addr   ({2'b00, mem_alu[31:2]}),
        .wdata  (mem_store_data),
        .rdata  (dmem_rdata)
    );

    // memory to writeback register
    always_ff @(posedge clk)
    begin
        if (reset || !run)
            wb_stage_valid <= 1'b0;
        else
            wb_stage_valid <= mem_valid;
        wb_wa3    <= mem_wa3;
        wb_result <= mem_rf_src ? dmem_rdata : mem_alu;
        wb_we_rf  <= mem_we_rf;
    end

    // writeback port mirrors the register file write
    assign wb_valid = wb_stage_valid && wb_we_rf;
    assign wb_addr  = wb_wa3;
    assign wb_data  = wb_result;

    nf_hazard_unit hazard_unit
    (
        .wa3_imem       (mem_wa3),
        .we_rf_imem     (mem_valid && mem_we_rf),
        .wa3_iwb        (wb_wa3),
        .we_rf_iwb      (wb_valid),
        .ra1_iexe       (exe_ra1),
        .ra2_iexe       (exe_ra2),
        .rd1_bypass     (rd1_bypass),
        .rd2_bypass     (rd2_bypass),
        .wa3_iexe       (exe_wa3),
        .we_rf_iexe     (exe_valid && exe_we_rf),
        .rf_src_iexe    (exe_rf_src),
        .ra1_id         (ra1_id),
        .ra2_id         (ra2_id),
        .stall_if       (stall_if),
        .stall_id       (stall_id),
        .flush_iexe     (flush_iexe)
    );

endmodule : nf_pipe_core

/* rtl/nf_hazard_unit.sv */
// forwarding select and load-use stall logic between the decode, execute, memory and writeback stages
`timescale 1ns/1ns

module nf_hazard_unit
(
    // forwarding into execute
    input   nf_pkg::reg_addr_t  wa3_imem,
    input   logic               we_rf_imem,
    input   nf_pkg::reg_addr_t  wa3_iwb,
    input   logic               we_rf_iwb,
    input   nf_pkg::reg_addr_t  ra1_iexe,
    input   nf_pkg::reg_addr_t  ra2_iexe,
    output  nf_pkg::bypass_t    rd1_bypass,
    output  nf_pkg::bypass_t    rd2_bypass,
    // load-use detection
    input   nf_pkg::reg_addr_t  wa3_iexe,
    input   logic               we_rf_iexe,
    input   logic               rf_src_iexe,
    input   nf_pkg::reg_addr_t  ra1_id,
    input   nf_pkg::reg_addr_t  ra2_id,
    output  logic               stall_if,
    output  logic               stall_id,
    output  logic               flush_iexe
);

    logic load_use;

    // the younger result in the memory stage wins over writeback
    always_comb
    begin
        rd1_bypass = nf_pkg::BP_NONE;
        rd2_bypass = nf_pkg::BP_NONE;
        case (1'b1)
            (we_rf_imem && (wa3_imem == ra1_iexe)): rd1_bypass = nf_pkg::BP_MEM;
            (we_rf_iwb  && (wa3_iwb  == ra1_iexe)): rd1_bypass = nf_pkg::BP_WB;
            default: ;
        endcase
        case (1'b1)
            (we_rf_imem && (wa3_imem == ra2_iexe)): rd2_bypass = nf_pkg::BP_MEM;
            (we_rf_iwb  && (wa3_iwb  == ra2_iexe)): rd2_bypass = nf_pkg::BP_WB;
            default: ;
        endcase
    end

    // load in execute whose target is read in decode
    assign load_use = we_rf_iexe && rf_src_iexe &&
                      ((ra1_id == wa3_iexe) || (ra2_id == wa3_iexe));

    assign stall_if   = load_use; // hold the pc
    assign stall_id   = load_use; // hold the decode register
    assign flush_iexe = load_use; // bubble into execute

endmodule : nf_hazard_unit

/* rtl/nf_decoder.sv */
// combinational instruction decoder for the decode stage of the pipeline
`timescale 1ns/1ns

module nf_decoder
(
    input   nf_pkg::word_t      instr,
    output  nf_pkg::reg_addr_t  ra1,
    output  nf_pkg::reg_addr_t  ra2,
    output  nf_pkg::reg_addr_t  wa3,
    output  nf_pkg::word_t      imm,
    output  nf_pkg::alu_op_t    alu_op,
    output  logic               alu_src_imm,
    output  logic               we_rf,
    output  logic               rf_src,     // 1 selects the load result
    output  logic               we_mem
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rs1;
    logic       use_rs2;
    logic       writes_rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        writes_rd   = 1'b0;
        alu_op      = nf_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        rf_src      = 1'b0;
        we_mem      = 1'b0;
        case (opcode)
            nf_pkg::OP_R:
            begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'b0, nf_pkg::F3_ADD_SUB}:         alu_op = nf_pkg::ALU_ADD;
                    {nf_pkg::F7_SUB, nf_pkg::F3_ADD_SUB}: alu_op = nf_pkg::ALU_SUB;
                    {7'b0, nf_pkg::F3_AND}:             alu_op = nf_pkg::ALU_AND;
                    {7'b0, nf_pkg::F3_OR}:              alu_op = nf_pkg::ALU_OR;
                    default:
                    begin
                        use_rs1   = 1'b0; // unsupported r-type, becomes a bubble
                        use_rs2   = 1'b0;
                        writes_rd = 1'b0;
                    end
                endcase
            end
            nf_pkg::OP_I:
            begin
                use_rs1     = (funct3 == nf_pkg::F3_ADD_SUB);
                writes_rd   = (funct3 == nf_pkg::F3_ADD_SUB);
                alu_src_imm = 1'b1;
            end
            nf_pkg::OP_LOAD:
            begin
                use_rs1     = (funct3 == nf_pkg::F3_LW_SW);
                writes_rd   = (funct3 == nf_pkg::F3_LW_SW);
                alu_src_imm = 1'b1;
                rf_src      = 1'b1;
            end
            nf_pkg::OP_STORE:
            begin
                use_rs1     = (funct3 == nf_pkg::F3_LW_SW);
                use_rs2     = (funct3 == nf_pkg::F3_LW_SW);
                alu_src_imm = 1'b1;
                we_mem      = (funct3 == nf_pkg::F3_LW_SW);
            end
            default: ;
        endcase
    end

    // unused source fields read as x0 so they never match a hazard
    assign ra1   = use_rs1 ? instr[19:15] : '0;
    assign ra2   = use_rs2 ? instr[24:20] : '0;
    assign wa3   = writes_rd ? instr[11:7] : '0;
    assign we_rf = writes_rd && (instr[11:7] != '0);  // writes to x0 are dropped here

    // s-format immediate only for stores
    assign imm = (opcode == nf_pkg::OP_STORE) ? {{20{instr[31]}}, instr[31:25], instr[11:7]}
                                              : {{20{instr[31]}}, instr[31:20]};

endmodule : nf_decoder

/* rtl/nf_reg_file.sv */
// integer register file with two read ports and one write port, used by the decode and writeback stages
`timescale 1ns/1ns

module nf_reg_file
(
    input   logic               clk,
    input   nf_pkg::reg_addr_t  ra1,
    input   nf_pkg::reg_addr_t  ra2,
    output  nf_pkg::word_t      rd1,
    output  nf_pkg::word_t      rd2,
    input   nf_pkg::reg_addr_t  wa3,
    input   logic               we3,
    input   nf_pkg::word_t      wd3
);

    nf_pkg::word_t regs [31:1]; // x0 has no storage

    always_ff @(posedge clk)
    begin
        if (we3 && (wa3 != '0))
        begin
            regs[wa3] <= wd3;
        end
    end

    // a write in the same cycle is passed straight through to the reader,
    // covering a producer three slots ahead
    assign rd1 = (ra1 == '0)               ? '0  :
                 (we3 && (wa3 == ra1))     ? wd3 :
                                             regs[ra1];

    assign rd2 = (ra2 == '0)               ? '0  :
                 (we3 && (wa3 == ra2))     ? wd3 :
                                             regs[ra2];

endmodule : nf_reg_file

/* rtl/nf_ram.sv */
// word-addressed memory with asynchronous read and clocked write, instanced for instruction and data
`timescale 1ns/1ns

module nf_ram
#(
    parameter DEPTH = 64
)
(
    input   logic           clk,
    input   logic           we,
    input   nf_pkg::word_t  addr,   // word index, not bytes
    input   nf_pkg::word_t  wdata,
    output  nf_pkg::word_t  rdata
);

    nf_pkg::word_t mem [DEPTH];
    nf_pkg::word_t idx;

    // out of range addresses wrap around
    assign idx = addr % DEPTH;

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx]; // read in the same cycle as the address

endmodule : nf_ram

/* rtl/nf_pkg.sv */
// shared types and RV32I subset encodings, referenced by scoped name from the core and testbench
package nf_pkg;

    typedef logic [31:0] word_t;     // data, instruction and address word
    typedef logic [4:0]  reg_addr_t; // register index
    typedef logic [1:0]  bypass_t;   // operand source select in execute
    typedef logic [1:0]  alu_op_t;

    // operand sources for the execute stage
    localparam bypass_t BP_NONE = 2'b00; // register file value
    localparam bypass_t BP_MEM  = 2'b01; // result held in the memory stage
    localparam bypass_t BP_WB   = 2'b10; // result held in the writeback stage

    localparam alu_op_t ALU_ADD = 2'b00;
    localparam alu_op_t ALU_SUB = 2'b01;
    localparam alu_op_t ALU_AND = 2'b10;
    localparam alu_op_t ALU_OR  = 2'b11;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_R     = 7'b0110011; // add sub and or
    localparam logic [6:0] OP_I     = 7'b0010011; // addi
    localparam logic [6:0] OP_LOAD  = 7'b0000011; // lw
    localparam logic [6:0] OP_STORE = 7'b0100011; // sw

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage : nf_pkg
